//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module commit_tb -f sim.f -o commit_sim
	./obj_dir/commit_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim.f
source/commit_pkg.sv
source/wb_stage.sv
source/commit_ctrl.sv
source/reg_file.sv
source/store_commit_mem.sv
source/commit_top.sv
verification/commit_tb.sv

//--- source/commit_ctrl.sv
`timescale 1ns/10ps

module commit_ctrl
    import commit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  wb_valid_i,
    input  logic [XLEN-1:0]       wb_pc_i,
    input  logic [XLEN-1:0]       wb_instr_i,
    input  logic                  wb_excp_i,
    input  logic [EXCP_NUM_W-1:0] wb_excp_num_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [XLEN-1:0]       wb_wdata_i,
    input  logic                  wb_llbit_we_i,
    input  logic                  wb_llbit_value_i,
    input  logic                  wb_is_cnt_i,
    input  logic                  wb_ld_en_i,
    input  logic                  wb_st_en_i,

    output logic                  rf_we_o,
    output logic [REG_ADDR_W-1:0] rf_waddr_o,
    output logic [XLEN-1:0]       rf_wdata_o,
    output logic                  llbit_o,

    output logic                  commit_valid_o,
    output logic [XLEN-1:0]       commit_pc_o,
    output logic [XLEN-1:0]       commit_instr_o,
    output logic                  commit_is_cnt_o,
    output logic                  commit_ld_en_o,
    output logic                  commit_st_en_o,

    output logic [CNT_W-1:0]      commit_count_o,
    output logic [CNT_W-1:0]      excp_count_o,
    output logic [EXCP_NUM_W-1:0] last_excp_num_o,
    output logic [XLEN-1:0]       last_excp_pc_o
);

    logic            done_q;
    logic [XLEN-1:0] last_pc_q;
    logic            last_valid_q;
    logic            new_rec;
    logic            active;
    logic            retire;

    // a new capture shows up as a change of pc or valid.
    assign new_rec = (wb_pc_i != last_pc_q) | (wb_valid_i != last_valid_q);
    assign active  = wb_valid_i & (~done_q | new_rec);
    assign retire  = active & ~wb_excp_i;

    assign rf_we_o    = retire & wb_we_i;
    assign rf_waddr_o = wb_waddr_i;
    assign rf_wdata_o = wb_wdata_i;

    // difftest-style commit port.
    assign commit_valid_o  = active;
    assign commit_pc_o     = wb_pc_i;
    assign commit_instr_o  = wb_instr_i;
    assign commit_is_cnt_o = wb_is_cnt_i;
    assign commit_ld_en_o  = wb_ld_en_i;
    assign commit_st_en_o  = wb_st_en_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q          <= 1'b0;
            last_pc_q       <= '0;
            last_valid_q    <= 1'b0;
            llbit_o         <= 1'b0;
            commit_count_o  <= '0;
            excp_count_o    <= '0;
            last_excp_num_o <= '0;
            last_excp_pc_o  <= '0;
        end else begin
            done_q       <= wb_valid_i;  // seen once, held copies are skipped.
            last_pc_q    <= wb_pc_i;
            last_valid_q <= wb_valid_i;
            if (retire) begin
                commit_count_o <= commit_count_o + 1'b1;
                if (wb_llbit_we_i) begin
                    llbit_o <= wb_llbit_value_i;
                end
            end
            if (active && wb_excp_i) begin
                excp_count_o    <= excp_count_o + 1'b1;
                last_excp_num_o <= wb_excp_num_i;
                last_excp_pc_o  <= wb_pc_i;
            end
        end
    end

endmodule

//--- source/commit_pkg.sv
package commit_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = 6;  // word index, address bits 7:2.
    localparam int EXCP_NUM_W  = 16;
    localparam int CNT_W       = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation codes seen at writeback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00,
        ALU_ADD    = 8'h01,
        ALU_OR     = 8'h02,
        OP_LD_W    = 8'h10,
        OP_ST_W    = 8'h11,
        OP_LL_W    = 8'h12,  // load linked, sets llbit.
        OP_SC_W    = 8'h13,  // store conditional, clears llbit.
        OP_RDCNTVL = 8'h20,
        OP_RDCNTVH = 8'h21,
        OP_RDCNTID = 8'h22
    } aluop_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception numbers, loongarch ecode values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [15:0] {
        EXC_NONE = 16'h0000,
        EXC_ALE  = 16'h0009,  // misaligned access.
        EXC_SYS  = 16'h000b,
        EXC_BRK  = 16'h000c,
        EXC_INE  = 16'h000d
    } excp_code_e;

endpackage

//--- source/commit_top.sv
`timescale 1ns/10ps

module commit_top
    import commit_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic                   advance_i,

    input  logic                   mem_valid_i,
    input  logic [XLEN-1:0]        mem_pc_i,
    input  logic [XLEN-1:0]        mem_instr_i,
    input  aluop_e                 mem_aluop_i,
    input  logic                   mem_wreg_i,
    input  logic [REG_ADDR_W-1:0]  mem_waddr_i,
    input  logic [XLEN-1:0]        mem_wdata_i,
    input  logic                   mem_load_i,
    input  logic                   mem_store_i,
    input  logic [XLEN-1:0]        mem_addr_i,
    input  logic [XLEN-1:0]        mem_store_data_i,
    input  logic                   mem_excp_i,
    input  logic [EXCP_NUM_W-1:0]  mem_excp_num_i,
    input  logic                   mem_llbit_we_i,
    input  logic                   mem_llbit_value_i,

    input  logic [REG_ADDR_W-1:0]  rf_raddr_a_i,
    input  logic [REG_ADDR_W-1:0]  rf_raddr_b_i,
    input  logic [DMEM_ADDR_W-1:0] dmem_raddr_i,

    output logic                   fwd_we_o,
    output logic [REG_ADDR_W-1:0]  fwd_addr_o,
    output logic [XLEN-1:0]        fwd_data_o,
    output logic                   dcache_flush_o,
    output logic                   dcache_store_commit_o,

    output logic                   commit_valid_o,
    output logic [XLEN-1:0]        commit_pc_o,
    output logic [XLEN-1:0]        commit_instr_o,
    output logic                   commit_is_cnt_o,
    output logic                   commit_ld_en_o,
    output logic                   commit_st_en_o,
    output logic [XLEN-1:0]        commit_mem_addr_o,
    output logic [XLEN-1:0]        commit_st_data_o,

    output logic                   llbit_o,
    output logic [CNT_W-1:0]       commit_count_o,
    output logic [CNT_W-1:0]       excp_count_o,
    output logic [EXCP_NUM_W-1:0]  last_excp_num_o,
    output logic [XLEN-1:0]        last_excp_pc_o,

    output logic [XLEN-1:0]        rf_rdata_a_o,
    output logic [XLEN-1:0]        rf_rdata_b_o,
    output logic [XLEN-1:0]        dmem_rdata_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wb stage record
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic                  wb_valid;
    logic [XLEN-1:0]       wb_pc;
    logic [XLEN-1:0]       wb_instr;
    logic                  wb_excp;
    logic [EXCP_NUM_W-1:0] wb_excp_num;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_waddr;
    logic [XLEN-1:0]       wb_wdata;
    logic                  wb_llbit_we;
    logic                  wb_llbit_value;
    logic                  wb_is_cnt;
    logic                  wb_ld_en;
    logic                  wb_st_en;

    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    wb_stage u_wb_stage (
        .clk                   (clk),
        .rst                   (rst),
        .flush_i               (flush_i),
        .advance_i             (advance_i),
        .mem_valid_i           (mem_valid_i),
        .mem_pc_i              (mem_pc_i),
        .mem_instr_i           (mem_instr_i),
        .mem_aluop_i           (mem_aluop_i),
        .mem_wreg_i            (mem_wreg_i),
        .mem_waddr_i           (mem_waddr_i),
        .mem_wdata_i           (mem_wdata_i),
        .mem_load_i            (mem_load_i),
        .mem_store_i           (mem_store_i),
        .mem_addr_i            (mem_addr_i),
        .mem_store_data_i      (mem_store_data_i),
        .mem_excp_i            (mem_excp_i),
        .mem_excp_num_i        (mem_excp_num_i),
        .mem_llbit_we_i        (mem_llbit_we_i),
        .mem_llbit_value_i     (mem_llbit_value_i),
        .wb_valid_o            (wb_valid),
        .wb_pc_o               (wb_pc),
        .wb_instr_o            (wb_instr),
        .wb_excp_o             (wb_excp),
        .wb_excp_num_o         (wb_excp_num),
        .wb_we_o               (wb_we),
        .wb_waddr_o            (wb_waddr),
        .wb_wdata_o            (wb_wdata),
        .wb_llbit_we_o         (wb_llbit_we),
        .wb_llbit_value_o      (wb_llbit_value),
        .wb_is_cnt_o           (wb_is_cnt),
        .wb_ld_en_o            (wb_ld_en),
        .wb_st_en_o            (wb_st_en),
        .wb_mem_addr_o         (commit_mem_addr_o),  // store addr for difftest.
        .wb_st_data_o          (commit_st_data_o),
        .fwd_we_o              (fwd_we_o),
        .fwd_addr_o            (fwd_addr_o),
        .fwd_data_o            (fwd_data_o),
        .dcache_flush_o        (dcache_flush_o),
        .dcache_store_commit_o (dcache_store_commit_o)
    );

    commit_ctrl u_commit_ctrl (
        .clk              (clk),
        .rst              (rst),
        .wb_valid_i       (wb_valid),
        .wb_pc_i          (wb_pc),
        .wb_instr_i       (wb_instr),
        .wb_excp_i        (wb_excp),
        .wb_excp_num_i    (wb_excp_num),
        .wb_we_i          (wb_we),
        .wb_waddr_i       (wb_waddr),
        .wb_wdata_i       (wb_wdata),
        .wb_llbit_we_i    (wb_llbit_we),
        .wb_llbit_value_i (wb_llbit_value),
        .wb_is_cnt_i      (wb_is_cnt),
        .wb_ld_en_i       (wb_ld_en),
        .wb_st_en_i       (wb_st_en),
        .rf_we_o          (rf_we),
        .rf_waddr_o       (rf_waddr),
        .rf_wdata_o       (rf_wdata),
        .llbit_o          (llbit_o),
        .commit_valid_o   (commit_valid_o),
        .commit_pc_o      (commit_pc_o),
        .commit_instr_o   (commit_instr_o),
        .commit_is_cnt_o  (commit_is_cnt_o),
        .commit_ld_en_o   (commit_ld_en_o),
        .commit_st_en_o   (commit_st_en_o),
        .commit_count_o   (commit_count_o),
        .excp_count_o     (excp_count_o),
        .last_excp_num_o  (last_excp_num_o),
        .last_excp_pc_o   (last_excp_pc_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rf_raddr_a_i),
        .raddr_b_i (rf_raddr_b_i),
        .rdata_a_o (rf_rdata_a_o),
        .rdata_b_o (rf_rdata_b_o)
    );

    // stores land at the advance edge, straight from the mem stage.
    store_commit_mem u_store_commit_mem (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .advance_i      (advance_i),
        .store_commit_i (dcache_store_commit_o),
        .addr_i         (mem_addr_i),
        .data_i         (mem_store_data_i),
        .raddr_i        (dmem_raddr_i),
        .rdata_o        (dmem_rdata_o)
    );

endmodule

//--- source/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import commit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr_a_i,
    input  logic [REG_ADDR_W-1:0] raddr_b_i,
    output logic [XLEN-1:0]       rdata_a_o,
    output logic [XLEN-1:0]       rdata_b_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // r0 is hardwired.
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- source/store_commit_mem.sv
`timescale 1ns/10ps

module store_commit_mem
    import commit_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic                   advance_i,
    input  logic                   store_commit_i,
    input  logic [XLEN-1:0]        addr_i,
    input  logic [XLEN-1:0]        data_i,
    input  logic [DMEM_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]        rdata_o
);

    logic [XLEN-1:0]        mem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] clr_idx_q;
    logic                   clr_busy_q;
    logic [DMEM_ADDR_W-1:0] widx;
    logic                   wr_en;

    assign widx  = addr_i[DMEM_ADDR_W+1:2];
    assign wr_en = advance_i & store_commit_i & ~flush_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clear sweep, one word per cycle after reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_idx_q  <= '0;
            clr_busy_q <= 1'b1;
        end else if (clr_busy_q) begin
            clr_idx_q <= clr_idx_q + 1'b1;
            if (clr_idx_q == DMEM_ADDR_W'(DMEM_DEPTH - 1)) begin
                clr_busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_busy_q) begin
            mem[clr_idx_q] <= '0;
        end else if (wr_en) begin
            mem[widx] <= data_i;  // committed store.
        end
    end

    assign rdata_o = mem[raddr_i];

endmodule

//--- source/wb_stage.sv
`timescale 1ns/10ps

module wb_stage
    import commit_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  logic                  advance_i,

    input  logic                  mem_valid_i,
    input  logic [XLEN-1:0]       mem_pc_i,
    input  logic [XLEN-1:0]       mem_instr_i,
    input  aluop_e                mem_aluop_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_waddr_i,
    input  logic [XLEN-1:0]       mem_wdata_i,
    input  logic                  mem_load_i,
    input  logic                  mem_store_i,
    input  logic [XLEN-1:0]       mem_addr_i,
    input  logic [XLEN-1:0]       mem_store_data_i,
    input  logic                  mem_excp_i,
    input  logic [EXCP_NUM_W-1:0] mem_excp_num_i,
    input  logic                  mem_llbit_we_i,
    input  logic                  mem_llbit_value_i,

    output logic                  wb_valid_o,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic [XLEN-1:0]       wb_instr_o,
    output logic                  wb_excp_o,
    output logic [EXCP_NUM_W-1:0] wb_excp_num_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_waddr_o,
    output logic [XLEN-1:0]       wb_wdata_o,
    output logic                  wb_llbit_we_o,
    output logic                  wb_llbit_value_o,
    output logic                  wb_is_cnt_o,
    output logic                  wb_ld_en_o,
    output logic                  wb_st_en_o,
    output logic [XLEN-1:0]       wb_mem_addr_o,
    output logic [XLEN-1:0]       wb_st_data_o,

    output logic                  fwd_we_o,
    output logic [REG_ADDR_W-1:0] fwd_addr_o,
    output logic [XLEN-1:0]       fwd_data_o,

    output logic                  dcache_flush_o,
    output logic                  dcache_store_commit_o
);

    logic is_cnt;

    assign is_cnt = mem_aluop_i inside {OP_RDCNTVL, OP_RDCNTVH, OP_RDCNTID};

    // forwarding to dispatch, zero latency.
    assign fwd_we_o   = mem_wreg_i;
    assign fwd_addr_o = mem_waddr_i;
    assign fwd_data_o = mem_wdata_i;

    assign dcache_flush_o        = mem_excp_i;
    assign dcache_store_commit_o = mem_store_i & ~mem_excp_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin  // flush beats advance.
            wb_valid_o       <= 1'b0;
            wb_pc_o          <= '0;
            wb_instr_o       <= '0;
            wb_excp_o        <= 1'b0;
            wb_excp_num_o    <= EXC_NONE;
            wb_we_o          <= 1'b0;
            wb_waddr_o       <= '0;
            wb_wdata_o       <= '0;
            wb_llbit_we_o    <= 1'b0;
            wb_llbit_value_o <= 1'b0;
            wb_is_cnt_o      <= 1'b0;
            wb_ld_en_o       <= 1'b0;
            wb_st_en_o       <= 1'b0;
            wb_mem_addr_o    <= '0;
            wb_st_data_o     <= '0;
        end else if (advance_i) begin
            wb_valid_o       <= mem_valid_i;
            wb_pc_o          <= mem_pc_i;
            wb_instr_o       <= mem_instr_i;
            wb_excp_o        <= mem_excp_i;
            wb_excp_num_o    <= mem_excp_i ? mem_excp_num_i : EXC_NONE;  // no stale codes.
            wb_we_o          <= mem_wreg_i;
            wb_waddr_o       <= mem_waddr_i;
            wb_wdata_o       <= mem_wdata_i;
            wb_llbit_we_o    <= mem_llbit_we_i;
            wb_llbit_value_o <= mem_llbit_value_i;
            wb_is_cnt_o      <= is_cnt;
            wb_ld_en_o       <= mem_load_i;
            wb_st_en_o       <= mem_store_i;
            wb_mem_addr_o    <= mem_addr_i;  // no translation, one address.
            wb_st_data_o     <= mem_store_data_i;
        end
    end

endmodule

//--- verification/commit_tb.sv
`timescale 1ns/10ps

module commit_tb
    import commit_pkg::*;
();

    localparam int N_T1        = 40;
    localparam int N_T2        = 200;
    localparam int N_T3        = 150;
    localparam int N_T4        = 200;
    localparam int N_T5        = 150;
    localparam int N_TOTAL     = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;
    localparam int WATCHDOG_NS = (N_TOTAL * 4 + 2000) * 8;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       instr;
        aluop_e                aluop;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  load;
        logic                  store;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       sdata;
        logic                  excp;
        logic [EXCP_NUM_W-1:0] excp_num;
        logic                  llbit_we;
        logic                  llbit_value;
    } rec_t;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   advance;
    rec_t                   cur;  // record at the mem-stage inputs.
    logic [REG_ADDR_W-1:0]  raddr_a;
    logic [REG_ADDR_W-1:0]  raddr_b;
    logic [DMEM_ADDR_W-1:0] dmem_raddr;

    logic                   fwd_we;
    logic [REG_ADDR_W-1:0]  fwd_addr;
    logic [XLEN-1:0]        fwd_data;
    logic                   dc_flush;
    logic                   dc_store;
    logic                   commit_valid;
    logic [XLEN-1:0]        commit_pc;
    logic [XLEN-1:0]        commit_instr;
    logic                   commit_is_cnt;
    logic                   commit_ld_en;
    logic                   commit_st_en;
    logic [XLEN-1:0]        commit_mem_addr;
    logic [XLEN-1:0]        commit_st_data;
    logic                   llbit;
    logic [CNT_W-1:0]       commit_count;
    logic [CNT_W-1:0]       excp_count;
    logic [EXCP_NUM_W-1:0]  last_excp_num;
    logic [XLEN-1:0]        last_excp_pc;
    logic [XLEN-1:0]        rf_rdata_a;
    logic [XLEN-1:0]        rf_rdata_b;
    logic [XLEN-1:0]        dmem_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [XLEN-1:0]       m_regs [NUM_REGS];
    logic [XLEN-1:0]       m_mem [DMEM_DEPTH];
    logic                  m_llbit;
    logic [CNT_W-1:0]      m_commits;
    logic [CNT_W-1:0]      m_excps;
    logic [EXCP_NUM_W-1:0] m_last_num;
    logic [XLEN-1:0]       m_last_pc;
    rec_t                  exp_q [$];  // captured and waiting for the commit port.
    logic [XLEN-1:0]       next_pc;
    int                    errors;
    int                    tests_run;
    int                    tests_bad;
    int                    commits_seen;

    commit_top UUT (
        .clk(clk), .rst(rst), .flush_i(flush), .advance_i(advance),
        .mem_valid_i(cur.valid), .mem_pc_i(cur.pc), .mem_instr_i(cur.instr),
        .mem_aluop_i(cur.aluop), .mem_wreg_i(cur.wreg), .mem_waddr_i(cur.waddr),
        .mem_wdata_i(cur.wdata), .mem_load_i(cur.load), .mem_store_i(cur.store),
        .mem_addr_i(cur.addr), .mem_store_data_i(cur.sdata), .mem_excp_i(cur.excp),
        .mem_excp_num_i(cur.excp_num), .mem_llbit_we_i(cur.llbit_we),
        .mem_llbit_value_i(cur.llbit_value),
        .rf_raddr_a_i(raddr_a), .rf_raddr_b_i(raddr_b), .dmem_raddr_i(dmem_raddr),
        .fwd_we_o(fwd_we), .fwd_addr_o(fwd_addr), .fwd_data_o(fwd_data),
        .dcache_flush_o(dc_flush), .dcache_store_commit_o(dc_store),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
        .commit_instr_o(commit_instr), .commit_is_cnt_o(commit_is_cnt),
        .commit_ld_en_o(commit_ld_en), .commit_st_en_o(commit_st_en),
        .commit_mem_addr_o(commit_mem_addr), .commit_st_data_o(commit_st_data),
        .llbit_o(llbit), .commit_count_o(commit_count), .excp_count_o(excp_count),
        .last_excp_num_o(last_excp_num), .last_excp_pc_o(last_excp_pc),
        .rf_rdata_a_o(rf_rdata_a), .rf_rdata_b_o(rf_rdata_b), .dmem_rdata_o(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic is_counter_op(input aluop_e op);
        return (op == OP_RDCNTVL) || (op == OP_RDCNTVH) || (op == OP_RDCNTID);
    endfunction

    // retires one captured record into the model.
    function automatic void apply_record(input rec_t r);
        if (r.excp) begin
            m_excps    = m_excps + 1;
            m_last_num = r.excp_num;
            m_last_pc  = r.pc;
        end else begin
            m_commits = m_commits + 1;
            if (r.wreg && (r.waddr != 0)) begin
                m_regs[r.waddr] = r.wdata;
            end
            if (r.llbit_we) begin
                m_llbit = r.llbit_value;
            end
            if (r.store) begin
                m_mem[r.addr[7:2]] = r.sdata;
            end
        end
    endfunction

    function automatic void report_mismatch(input string name,
                                            input logic [XLEN-1:0] expected,
                                            input logic [XLEN-1:0] actual);
        errors++;
        $display("CHECK FAILED %s expected %h got %h", name, expected, actual);
    endfunction

    // kind selects alu (1), load/store (2), ll/sc with exceptions (3) or any (0).
    function automatic rec_t make_record(input int kind);
        rec_t r;
        int   pick;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = next_pc;
        r.instr = $urandom;
        r.waddr = REG_ADDR_W'($urandom);
        r.wdata = $urandom;
        r.addr  = $urandom & 32'hffff_fffc;
        r.sdata = $urandom;
        next_pc = next_pc + 4;
        pick    = (kind == 0) ? int'($urandom_range(3, 1)) : kind;
        case (pick)
            1: begin
                case ($urandom_range(5))
                    0: r.aluop = ALU_NOP;
                    1: r.aluop = ALU_ADD;
                    2: r.aluop = ALU_OR;
                    3: r.aluop = OP_RDCNTVL;
                    4: r.aluop = OP_RDCNTVH;
                    default: r.aluop = OP_RDCNTID;
                endcase
                r.wreg = (r.aluop != ALU_NOP);
            end
            2: begin
                r.store = 1'($urandom_range(1));
                r.load  = ~r.store;
                r.aluop = r.store ? OP_ST_W : OP_LD_W;
                r.wreg  = r.load;
                if ($urandom_range(3) == 0) begin  // misaligned address raises ale.
                    r.addr[0]  = 1'b1;
                    r.excp     = 1'b1;
                    r.excp_num = EXC_ALE;
                end
            end
            default: begin
                case ($urandom_range(2))
                    0: begin
                        r.aluop       = OP_LL_W;
                        r.load        = 1'b1;
                        r.llbit_value = 1'b1;
                    end
                    1: begin
                        r.aluop = OP_SC_W;
                        r.store = 1'b1;
                    end
                    default: r.aluop = ALU_ADD;
                endcase
                r.wreg     = 1'b1;
                r.llbit_we = (r.aluop == OP_LL_W) || (r.aluop == OP_SC_W);
                if ($urandom_range(9) < 4) begin
                    r.excp = 1'b1;
                    case ($urandom_range(3))
                        0: r.excp_num = EXC_ALE;
                        1: r.excp_num = EXC_SYS;
                        2: r.excp_num = EXC_BRK;
                        default: r.excp_num = EXC_INE;
                    endcase
                end
            end
        endcase
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-cycle checker sampled on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        rec_t e;
        if (!rst) begin
            if (fwd_we !== cur.wreg) report_mismatch("fwd_we_o", cur.wreg, fwd_we);
            if (fwd_addr !== cur.waddr) report_mismatch("fwd_addr_o", cur.waddr, fwd_addr);
            if (fwd_data !== cur.wdata) report_mismatch("fwd_data_o", cur.wdata, fwd_data);
            if (dc_flush !== cur.excp) report_mismatch("dcache_flush_o", cur.excp, dc_flush);
            if (dc_store !== (cur.store & ~cur.excp)) begin
                report_mismatch("dcache_store_commit_o", cur.store & ~cur.excp, dc_store);
            end
            if (commit_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("commit of pc %h seen while no instruction was pending",
                             commit_pc);
                end else begin
                    e = exp_q.pop_front();
                    commits_seen++;
                    if (commit_pc !== e.pc) report_mismatch("commit_pc_o", e.pc, commit_pc);
                    if (commit_instr !== e.instr) begin
                        report_mismatch("commit_instr_o", e.instr, commit_instr);
                    end
                    if (commit_is_cnt !== is_counter_op(e.aluop)) begin
                        report_mismatch("commit_is_cnt_o", is_counter_op(e.aluop),
                                        commit_is_cnt);
                    end
                    if (commit_ld_en !== e.load) begin
                        report_mismatch("commit_ld_en_o", e.load, commit_ld_en);
                    end
                    if (commit_st_en !== e.store) begin
                        report_mismatch("commit_st_en_o", e.store, commit_st_en);
                    end
                    if (commit_mem_addr !== e.addr) begin
                        report_mismatch("commit_mem_addr_o", e.addr, commit_mem_addr);
                    end
                    if (commit_st_data !== e.sdata) begin
                        report_mismatch("commit_st_data_o", e.sdata, commit_st_data);
                    end
                end
            end
        end
    end

    // one clock of stimulus; the record driven last edge is accounted first.
    task automatic step(input rec_t r, input logic adv, input logic fl);
        @(posedge clk);
        if (advance && !flush && cur.valid) begin
            apply_record(cur);
            exp_q.push_back(cur);
        end
        cur     <= r;
        advance <= adv;
        flush   <= fl;
    endtask

    task automatic check_state();
        for (int i = 0; i < NUM_REGS; i++) begin
            @(posedge clk);
            raddr_a <= REG_ADDR_W'(i);
            raddr_b <= REG_ADDR_W'(NUM_REGS - 1 - i);
            @(negedge clk);
            if (rf_rdata_a !== m_regs[i]) report_mismatch("rf_rdata_a_o", m_regs[i], rf_rdata_a);
            if (rf_rdata_b !== m_regs[NUM_REGS - 1 - i]) begin
                report_mismatch("rf_rdata_b_o", m_regs[NUM_REGS - 1 - i], rf_rdata_b);
            end
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            @(posedge clk);
            dmem_raddr <= DMEM_ADDR_W'(i);
            @(negedge clk);
            if (dmem_rdata !== m_mem[i]) report_mismatch("dmem_rdata_o", m_mem[i], dmem_rdata);
        end
        if (commit_count !== m_commits) report_mismatch("commit_count_o", m_commits, commit_count);
        if (excp_count !== m_excps) report_mismatch("excp_count_o", m_excps, excp_count);
        if (last_excp_num !== m_last_num) begin
            report_mismatch("last_excp_num_o", m_last_num, last_excp_num);
        end
        if (last_excp_pc !== m_last_pc) report_mismatch("last_excp_pc_o", m_last_pc, last_excp_pc);
        if (llbit !== m_llbit) report_mismatch("llbit_o", m_llbit, llbit);
    endtask

    task automatic run_test(input int num, input string name, input int count,
                            input int kind, input int stall_pct, input int flush_pct);
        rec_t r;
        rec_t bubble;
        logic adv;
        logic fl;
        int   start_errors;
        start_errors = errors;
        bubble       = '0;
        for (int i = 0; i < count; i++) begin
            r = make_record(kind);
            do begin  // a stalled record stays at the inputs.
                adv = ($urandom_range(99) >= stall_pct);
                fl  = ($urandom_range(99) < flush_pct);
                step(r, adv, fl);
            end while (!adv && !fl);
        end
        step(bubble, 1'b1, 1'b0);
        while (exp_q.size() != 0) begin
            step(bubble, 1'b1, 1'b0);
        end
        repeat (2) step(bubble, 1'b1, 1'b0);  // let the last retirement land.
        check_state();
        tests_run++;
        if (errors != start_errors) begin
            tests_bad++;
            $display("test %0d %s: FAIL, %0d mismatches", num, name, errors - start_errors);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    initial begin
        void'($urandom(35));
        rst          = 1'b1;
        flush        = 1'b0;
        advance      = 1'b0;
        cur          = '0;
        raddr_a      = '0;
        raddr_b      = '0;
        dmem_raddr   = '0;
        next_pc      = 32'h1c00_0000;
        errors       = 0;
        tests_run    = 0;
        tests_bad    = 0;
        commits_seen = 0;
        m_llbit      = 1'b0;
        m_commits    = '0;
        m_excps      = '0;
        m_last_num   = '0;
        m_last_pc    = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (70) @(posedge clk);  // memory clear sweep.

        run_test(1, "forwarding and strobes", N_T1, 0, 0, 0);
        run_test(2, "register retirement", N_T2, 1, 0, 0);
        run_test(3, "stores and loads", N_T3, 2, 0, 0);
        run_test(4, "stalls and flush", N_T4, 0, 30, 8);
        run_test(5, "exceptions and ll bit", N_T5, 3, 10, 0);

        $display("tests run %0d, tests with errors %0d, commits checked %0d, mismatches %0d",
                 tests_run, tests_bad, commits_seen, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
